// ==== rtl/sensor_pkg.sv ====
// Shared widths, timing constants and packet layout of the wake-triggered sensor core
`default_nettype none

package sensor_pkg;

    // ========================================================================
    // Datapath widths
    // ========================================================================
    localparam int adc_bits      = 4;
    localparam int sub_width     = 12;
    localparam int num_bands     = 8;
    localparam int band_idx_bits = 3;
    localparam int pow_width     = 16;
    localparam int sq_width      = 2 * sub_width;
    localparam int cmd_width     = 3;

    // Transform runs level 1, level 2, level 3, then output
    localparam int dwt_latency   = 4;

    // Frame sequencer states
    localparam int state_bits = 3;
    localparam logic [state_bits-1:0] st_idle      = 3'd0;
    localparam logic [state_bits-1:0] st_transform = 3'd1;
    localparam logic [state_bits-1:0] st_power     = 3'd2;
    localparam logic [state_bits-1:0] st_encode    = 3'd3;
    localparam logic [state_bits-1:0] st_transmit  = 3'd4;
    localparam logic [state_bits-1:0] st_sleep     = 3'd5;

    // ========================================================================
    // LSK packet
    // ========================================================================
    localparam int bit_period   = 200;
    localparam int half_bit     = bit_period / 2;
    localparam int timer_bits   = $clog2(bit_period);
    localparam int packet_bits  = 14;
    localparam int pkt_idx_bits = $clog2(packet_bits);

    localparam logic [3:0] preamble  = 4'b1010;
    localparam logic [3:0] sync_word = 4'b1100;
    localparam logic [1:0] postamble = 2'b11;

    // Built through the fields, shifted out MSB-first through the flat word
    typedef union packed {
        struct packed {
            logic [3:0]           preamble;
            logic [3:0]           sync;
            logic [cmd_width-1:0] command;
            logic                 parity;
            logic [1:0]           postamble;
        } fields;
        logic [packet_bits-1:0] flat;
    } lsk_packet_u;

endpackage

`default_nettype wire

// ==== rtl/wake_sequencer.sv ====
// Frame sequencer: input synchronizers, sample strobe and the per-frame stage FSM
`default_nettype none

module wake_sequencer
    import sensor_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic wake,
    input  logic adc_valid,
    input  logic dwt_done,
    input  logic pwr_done,
    input  logic enc_done,
    input  logic tx_active,
    output logic sample_stb,
    output logic dwt_start,
    output logic pwr_start,
    output logic enc_start,
    output logic tx_start,
    output logic processing
);

    logic                  wake_meta;
    logic                  wake_sync;
    logic                  adc_meta;
    logic                  adc_sync;
    logic                  adc_sync_q;
    logic                  tx_active_q;
    logic [state_bits-1:0] state;

    // ========================================================================
    // Synchronizers and sample edge detect
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wake_meta  <= 1'b0;
            wake_sync  <= 1'b0;
            adc_meta   <= 1'b0;
            adc_sync   <= 1'b0;
            adc_sync_q <= 1'b0;
            sample_stb <= 1'b0;
        end else begin
            wake_meta  <= wake;
            wake_sync  <= wake_meta;
            adc_meta   <= adc_valid;
            adc_sync   <= adc_meta;
            adc_sync_q <= adc_sync;
            // One pulse per rising edge of the clean adc_valid
            sample_stb <= adc_sync & ~adc_sync_q;
        end
    end

    // ========================================================================
    // Frame FSM
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            dwt_start   <= 1'b0;
            pwr_start   <= 1'b0;
            enc_start   <= 1'b0;
            tx_start    <= 1'b0;
            tx_active_q <= 1'b0;
        end else begin
            dwt_start   <= 1'b0;
            pwr_start   <= 1'b0;
            enc_start   <= 1'b0;
            tx_start    <= 1'b0;
            tx_active_q <= tx_active;
            case (state)
                st_idle: begin
                    if (wake_sync) begin
                        state     <= st_transform;
                        dwt_start <= 1'b1;
                    end
                end
                st_transform: begin
                    if (dwt_done) begin
                        state     <= st_power;
                        pwr_start <= 1'b1;
                    end
                end
                st_power: begin
                    if (pwr_done) begin
                        state     <= st_encode;
                        enc_start <= 1'b1;
                    end
                end
                st_encode: begin
                    if (enc_done) begin
                        state    <= st_transmit;
                        tx_start <= 1'b1;
                    end
                end
                st_transmit: begin
                    // Leave on the falling edge of the transmitter's active level
                    if (tx_active_q && !tx_active) begin
                        state <= st_sleep;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign processing = (state != st_idle) && (state != st_sleep);

endmodule

`default_nettype wire

// ==== rtl/haar_dwt.sv ====
// Circular sample buffer feeding a 3-level Haar lifting transform into 8 subbands
`default_nettype none

module haar_dwt
    import sensor_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [sub_width-1:0]                sample,
    input  logic                                sample_stb,
    input  logic                                dwt_start,
    output logic [num_bands-1:0][sub_width-1:0] subband,
    output logic                                dwt_done
);

    logic [sub_width-1:0]                  buffer [num_bands];
    logic [band_idx_bits-1:0]              wr_ptr;
    logic [dwt_latency-1:0]                stage;
    logic [num_bands/2-1:0][sub_width-1:0] l1_a;
    logic [num_bands/2-1:0][sub_width-1:0] l1_d;
    logic [num_bands/4-1:0][sub_width-1:0] l2_a;
    logic [num_bands/4-1:0][sub_width-1:0] l2_d;

    function automatic logic [sub_width-1:0] haar_detail(
        input logic [sub_width-1:0] a,
        input logic [sub_width-1:0] b
    );
        return b - a;
    endfunction

    // Approximation is a plus half the detail, rounded toward minus infinity
    function automatic logic [sub_width-1:0] haar_approx(
        input logic [sub_width-1:0] a,
        input logic [sub_width-1:0] b
    );
        logic signed [sub_width-1:0] d;
        logic signed [sub_width-1:0] half;
        d    = b - a;
        half = d >>> 1;
        return a + half;
    endfunction

    // ========================================================================
    // Sample buffer
    // ========================================================================
    // Pointer keeps running across frames so old samples stay usable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (sample_stb) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_stb) begin
            buffer[wr_ptr] <= sample;
        end
    end

    // ========================================================================
    // Lifting steps
    // ========================================================================
    // One-hot step marker: L1, L2, L3, output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage <= '0;
        end else begin
            stage <= {stage[dwt_latency-2:0], dwt_start && (stage == '0)};
        end
    end

    always_ff @(posedge clk) begin
        if (stage[0]) begin
            for (int i = 0; i < num_bands / 2; i++) begin
                l1_d[i] <= haar_detail(buffer[2*i], buffer[2*i+1]);
                l1_a[i] <= haar_approx(buffer[2*i], buffer[2*i+1]);
            end
        end
        if (stage[1]) begin
            for (int i = 0; i < num_bands / 4; i++) begin
                l2_d[i] <= haar_detail(l1_a[2*i], l1_a[2*i+1]);
                l2_a[i] <= haar_approx(l1_a[2*i], l1_a[2*i+1]);
            end
        end
        if (stage[2]) begin
            subband[0]   <= haar_approx(l2_a[0], l2_a[1]);
            subband[1]   <= haar_detail(l2_a[0], l2_a[1]);
            subband[3:2] <= l2_d;
            subband[7:4] <= l1_d;
        end
    end

    assign dwt_done = stage[dwt_latency-1];

endmodule

`default_nettype wire

// ==== rtl/band_power.sv ====
// Band power: magnitude squared of each subband through one shared multiplier
`default_nettype none

module band_power
    import sensor_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [num_bands-1:0][sub_width-1:0] subband,
    input  logic                                pwr_start,
    output logic [num_bands-1:0][pow_width-1:0] bin,
    output logic                                pwr_done
);

    logic [band_idx_bits-1:0] idx;
    logic                     running;
    logic [sub_width-1:0]     cur;
    logic [sub_width-1:0]     mag;
    logic [sq_width-1:0]      square;

    // Magnitude of the selected band, then the single multiplier
    assign cur    = subband[idx];
    assign mag    = cur[sub_width-1] ? (~cur + 1'b1) : cur;
    assign square = mag * mag;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx      <= '0;
            running  <= 1'b0;
            pwr_done <= 1'b0;
        end else begin
            pwr_done <= 1'b0;
            if (pwr_start && !running) begin
                running <= 1'b1;
                idx     <= '0;
            end else if (running) begin
                if (idx == band_idx_bits'(num_bands - 1)) begin
                    running  <= 1'b0;
                    pwr_done <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    // Keep the upper bits of the square
    always_ff @(posedge clk) begin
        if (running) begin
            bin[idx] <= square[sq_width-1 -: pow_width];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/peak_band_encoder.sv ====
// Peak band search: scans the bins one per cycle and reports the strongest index
`default_nettype none

module peak_band_encoder
    import sensor_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [num_bands-1:0][pow_width-1:0] bin,
    input  logic                                enc_start,
    output logic [cmd_width-1:0]                cmd,
    output logic                                enc_done
);

    logic [band_idx_bits:0]   scan_idx;
    logic                     scanning;
    logic [pow_width-1:0]     max_val;
    logic [band_idx_bits-1:0] max_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_idx <= '0;
            scanning <= 1'b0;
            cmd      <= '0;
            enc_done <= 1'b0;
        end else begin
            enc_done <= 1'b0;
            if (enc_start && !scanning) begin
                scanning <= 1'b1;
                scan_idx <= (band_idx_bits + 1)'(1);
            end else if (scanning) begin
                if (scan_idx == (band_idx_bits + 1)'(num_bands)) begin
                    scanning <= 1'b0;
                    cmd      <= max_idx;
                    enc_done <= 1'b1;
                end else begin
                    scan_idx <= scan_idx + 1'b1;
                end
            end
        end
    end

    // Strictly greater replaces, so ties keep the lower index
    always_ff @(posedge clk) begin
        if (enc_start && !scanning) begin
            max_val <= bin[0];
            max_idx <= '0;
        end else if (scanning && !scan_idx[band_idx_bits]) begin
            if (bin[scan_idx[band_idx_bits-1:0]] > max_val) begin
                max_val <= bin[scan_idx[band_idx_bits-1:0]];
                max_idx <= scan_idx[band_idx_bits-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/manchester_tx.sv ====
// LSK transmitter: builds the 14-bit packet and sends it Manchester coded, MSB first
`default_nettype none

module manchester_tx
    import sensor_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [cmd_width-1:0] cmd,
    input  logic                 tx_start,
    output logic                 lsk_ctrl,
    output logic                 tx_active
);

    lsk_packet_u             packet;
    logic [timer_bits-1:0]   bit_timer;
    logic [pkt_idx_bits-1:0] bit_idx;
    logic                    second_half;

    // ========================================================================
    // Packet builder
    // ========================================================================
    always_ff @(posedge clk) begin
        if (tx_start && !tx_active) begin
            packet.fields.preamble  <= preamble;
            packet.fields.sync      <= sync_word;
            packet.fields.command   <= cmd;
            packet.fields.parity    <= ^cmd;
            packet.fields.postamble <= postamble;
        end
    end

    // ========================================================================
    // Bit timer
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_active <= 1'b0;
            bit_timer <= '0;
            bit_idx   <= '0;
        end else if (tx_start && !tx_active) begin
            tx_active <= 1'b1;
            bit_timer <= '0;
            bit_idx   <= pkt_idx_bits'(packet_bits - 1);
        end else if (tx_active) begin
            if (bit_timer == timer_bits'(bit_period - 1)) begin
                bit_timer <= '0;
                // Last bit done ends the packet
                if (bit_idx == '0) begin
                    tx_active <= 1'b0;
                end else begin
                    bit_idx <= bit_idx - 1'b1;
                end
            end else begin
                bit_timer <= bit_timer + 1'b1;
            end
        end
    end

    // Data half first, then the inverted half
    assign second_half = (bit_timer >= timer_bits'(half_bit));
    assign lsk_ctrl    = tx_active & (packet.flat[bit_idx] ^ second_half);

endmodule

`default_nettype wire

// ==== rtl/neuro_sensor_top.sv ====
// Sensor core top level: sequencer, transform, power, peak search and LSK transmitter
`default_nettype none

module neuro_sensor_top
    import sensor_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [adc_bits-1:0]  adc_data,
    input  logic                 adc_valid,
    input  logic                 wake,
    output logic [cmd_width-1:0] cmd_out,
    output logic                 cmd_valid,
    output logic                 lsk_ctrl,
    output logic                 lsk_tx,
    output logic                 processing
);

    logic                                sample_stb;
    logic                                dwt_start;
    logic                                dwt_done;
    logic                                pwr_start;
    logic                                pwr_done;
    logic                                enc_start;
    logic                                enc_done;
    logic                                tx_start;
    logic [sub_width-1:0]                sample_ext;
    logic [num_bands-1:0][sub_width-1:0] subband;
    logic [num_bands-1:0][pow_width-1:0] bin;

    // Signed ADC code widened to the transform width
    assign sample_ext = {{(sub_width - adc_bits){adc_data[adc_bits-1]}}, adc_data};
    assign cmd_valid  = enc_done;

    // ========================================================================
    // Stage instances
    // ========================================================================
    wake_sequencer i_wake_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .wake       (wake),
        .adc_valid  (adc_valid),
        .dwt_done   (dwt_done),
        .pwr_done   (pwr_done),
        .enc_done   (enc_done),
        .tx_active  (lsk_tx),
        .sample_stb (sample_stb),
        .dwt_start  (dwt_start),
        .pwr_start  (pwr_start),
        .enc_start  (enc_start),
        .tx_start   (tx_start),
        .processing (processing)
    );

    haar_dwt i_haar_dwt (
        .clk        (clk),
        .rst_n      (rst_n),
        .sample     (sample_ext),
        .sample_stb (sample_stb),
        .dwt_start  (dwt_start),
        .subband    (subband),
        .dwt_done   (dwt_done)
    );

    band_power i_band_power (
        .clk       (clk),
        .rst_n     (rst_n),
        .subband   (subband),
        .pwr_start (pwr_start),
        .bin       (bin),
        .pwr_done  (pwr_done)
    );

    peak_band_encoder i_peak_band_encoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .bin       (bin),
        .enc_start (enc_start),
        .cmd       (cmd_out),
        .enc_done  (enc_done)
    );

    manchester_tx i_manchester_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd_out),
        .tx_start  (tx_start),
        .lsk_ctrl  (lsk_ctrl),
        .tx_active (lsk_tx)
    );

endmodule

`default_nettype wire

// ==== bench/sensor_props.sv ====
// Protocol properties on the sensor core top level, bound into neuro_sensor_top
`default_nettype none

module sensor_props (
    input logic clk,
    input logic rst_n,
    input logic cmd_valid,
    input logic lsk_ctrl,
    input logic lsk_tx,
    input logic processing
);
    timeunit 1ns;
    timeprecision 1ps;

    // Command strobe lasts one cycle
    cmd_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid |=> !cmd_valid)
        else $error("cmd_valid stayed high for more than one cycle");

    tx_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        lsk_tx |-> processing)
        else $error("lsk_tx high while processing is low");

    // No modulation outside the transmit window
    ctrl_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !lsk_tx |-> !lsk_ctrl)
        else $error("lsk_ctrl high while lsk_tx is low");

endmodule

bind neuro_sensor_top sensor_props i_sensor_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .lsk_ctrl   (lsk_ctrl),
    .lsk_tx     (lsk_tx),
    .processing (processing)
);

`default_nettype wire

// ==== bench/tb_neuro_sensor.sv ====
// Testbench for the sensor core with table-driven and random frames checked against
// a lifting, power and peak-search model, plus Manchester decoding of the LSK output
`default_nettype none

module tb_neuro_sensor
    import sensor_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_table       = 6;
    localparam int num_random      = 4;
    localparam int num_frames      = num_table + num_random;
    localparam int sample_cycles   = 8;
    localparam int frame_cycles    = 3000 + num_bands * sample_cycles;
    localparam int watchdog_cycles = num_frames * frame_cycles + 500;

    logic                 clk;
    logic                 rst_n;
    logic [adc_bits-1:0]  adc_data;
    logic                 adc_valid;
    logic                 wake;
    logic [cmd_width-1:0] cmd_out;
    logic                 cmd_valid;
    logic                 lsk_ctrl;
    logic                 lsk_tx;
    logic                 processing;

    int errors = 0;

    // Mirror of the DUT sample buffer and its write pointer
    logic [num_bands-1:0][adc_bits-1:0] model_buf;
    logic [band_idx_bits-1:0]           model_ptr;

    // Frame table with samples, count of new samples and expected command
    logic [num_bands-1:0][adc_bits-1:0] table_smp [num_table];
    int                                 table_len [num_table];
    logic [cmd_width-1:0]               table_cmd [num_table];

    neuro_sensor_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .adc_data   (adc_data),
        .adc_valid  (adc_valid),
        .wake       (wake),
        .cmd_out    (cmd_out),
        .cmd_valid  (cmd_valid),
        .lsk_ctrl   (lsk_ctrl),
        .lsk_tx     (lsk_tx),
        .processing (processing)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Finished with errors");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // ========================================================================
    // Reference model of lifting, magnitude squared and strict maximum
    // ========================================================================
    function automatic logic [cmd_width-1:0] model_cmd(
        input logic [num_bands-1:0][adc_bits-1:0] smp
    );
        logic signed [sub_width-1:0] a [num_bands];
        logic signed [sub_width-1:0] sb [num_bands];
        logic signed [sub_width-1:0] d;
        logic [sub_width-1:0]        mag;
        logic [2*sub_width-1:0]      sq;
        logic [pow_width-1:0]        pw;
        logic [pow_width-1:0]        best;
        logic [cmd_width-1:0]        idx;
        int                          n;
        for (int i = 0; i < num_bands; i++) begin
            a[i] = $signed(smp[i]);
        end
        // Details of a level with n inputs land in slots n/2 .. n-1
        n = num_bands;
        while (n > 1) begin
            for (int k = 0; k < n / 2; k++) begin
                d             = a[2*k+1] - a[2*k];
                sb[n / 2 + k] = d;
                a[k]          = a[2*k] + (d >>> 1);
            end
            n = n / 2;
        end
        sb[0] = a[0];
        best  = '0;
        idx   = '0;
        for (int i = 0; i < num_bands; i++) begin
            mag = sb[i][sub_width-1] ? -sb[i] : sb[i];
            sq  = mag * mag;
            pw  = sq[2*sub_width-1 -: pow_width];
            if (i == 0 || pw > best) begin
                best = pw;
                idx  = cmd_width'(i);
            end
        end
        return idx;
    endfunction

    // Advance the buffer mirror by count samples and predict the command
    function automatic logic [cmd_width-1:0] predict_cmd(
        input logic [num_bands-1:0][adc_bits-1:0] smp,
        input int                                 count
    );
        for (int i = 0; i < count; i++) begin
            model_buf[model_ptr] = smp[i];
            model_ptr            = model_ptr + 1'b1;
        end
        return model_cmd(model_buf);
    endfunction

    task automatic write_sample(input logic [adc_bits-1:0] s);
        adc_data  = s;
        adc_valid = 1'b1;
        repeat (sample_cycles / 2) @(negedge clk);
        adc_valid = 1'b0;
        repeat (sample_cycles / 2) @(negedge clk);
    endtask

    // ========================================================================
    // One frame with samples, wake, command and packet decode
    // ========================================================================
    task automatic run_frame(
        input logic [num_bands-1:0][adc_bits-1:0] smp,
        input int                                 count,
        input logic [cmd_width-1:0]               exp_cmd,
        input bit                                 equal_frame
    );
        logic [packet_bits-1:0] exp_pkt;
        logic [packet_bits-1:0] decoded;
        logic                   first;
        int                     cnt;
        int                     tx_cycles;
        int                     proc_cycles;
        for (int i = 0; i < count; i++) begin
            write_sample(smp[i]);
        end
        exp_pkt = {preamble, sync_word, exp_cmd, ^exp_cmd, postamble};
        check("processing before wake", processing, 1'b0);
        wake = 1'b1;
        repeat (3) @(negedge clk);
        wake = 1'b0;
        cnt = 0;
        while (!cmd_valid && cnt < 100) begin
            @(negedge clk);
            cnt++;
        end
        if (!cmd_valid) begin
            errors++;
            $display("cmd_valid never pulsed after wake");
        end
        check("cmd_out", cmd_out, exp_cmd);
        check("processing at cmd_valid", processing, 1'b1);
        if (equal_frame) begin
            check("cmd_out for equal samples", cmd_out, 0);
        end
        cnt = 0;
        while (!lsk_tx && cnt < 10) begin
            @(negedge clk);
            cnt++;
        end
        if (!lsk_tx) begin
            errors++;
            $display("lsk_tx did not rise after cmd_valid");
        end
        tx_cycles   = 0;
        proc_cycles = 0;
        first       = 1'b0;
        decoded     = '0;
        for (int t = 0; t < bit_period * packet_bits; t++) begin
            tx_cycles   += lsk_tx;
            proc_cycles += processing;
            if (t % bit_period == half_bit / 2) begin
                first = lsk_ctrl;
            end
            if (t % bit_period == bit_period - half_bit / 2) begin
                check("lsk_ctrl second half", lsk_ctrl, !first);
                decoded[packet_bits - 1 - t / bit_period] = first;
            end
            @(negedge clk);
        end
        check("lsk_tx high cycles", tx_cycles, bit_period * packet_bits);
        check("processing during lsk_tx", proc_cycles, bit_period * packet_bits);
        check("lsk_tx after packet", lsk_tx, 1'b0);
        check("lsk packet", decoded, exp_pkt);
        cnt = 0;
        while (processing && cnt < 5) begin
            @(negedge clk);
            cnt++;
        end
        if (processing) begin
            errors++;
            $display("processing stayed high after the packet");
        end
        repeat (2) @(negedge clk);
    endtask

    initial begin
        logic [num_bands-1:0][adc_bits-1:0] rnd;
        void'($urandom(32'h55cd_0982));
        rst_n     = 1'b0;
        adc_data  = '0;
        adc_valid = 1'b0;
        wake      = 1'b0;
        model_buf = '0;
        model_ptr = '0;
        // Equal samples first, half frames last so older samples remain
        table_smp[0] = {num_bands{4'h3}};
        table_len[0] = 8;
        table_smp[1] = 32'h7654_3210;
        table_len[1] = 8;
        table_smp[2] = 32'h7878_7878;
        table_len[2] = 8;
        table_smp[3] = 32'h1f2e_3d4c;
        table_len[3] = 8;
        table_smp[4] = 32'h0000_a5c3;
        table_len[4] = 4;
        table_smp[5] = 32'h0000_9876;
        table_len[5] = 4;
        for (int f = 0; f < num_table; f++) begin
            table_cmd[f] = predict_cmd(table_smp[f], table_len[f]);
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check("cmd_valid after reset", cmd_valid, 1'b0);
        check("lsk_ctrl after reset", lsk_ctrl, 1'b0);
        check("lsk_tx after reset", lsk_tx, 1'b0);
        check("processing after reset", processing, 1'b0);
        check("cmd_out after reset", cmd_out, 0);
        for (int f = 0; f < num_table; f++) begin
            run_frame(table_smp[f], table_len[f], table_cmd[f], f == 0);
        end
        for (int r = 0; r < num_random; r++) begin
            for (int i = 0; i < num_bands; i++) begin
                rnd[i] = adc_bits'($urandom);
            end
            run_frame(rnd, num_bands, predict_cmd(rnd, num_bands), 1'b0);
        end
        $display("Frames run: %0d, errors: %0d", num_frames, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/sensor_pkg.sv
rtl/wake_sequencer.sv
rtl/haar_dwt.sv
rtl/band_power.sv
rtl/peak_band_encoder.sv
rtl/manchester_tx.sv
rtl/neuro_sensor_top.sv
bench/sensor_props.sv
bench/tb_neuro_sensor.sv

// ==== Bender.yml ====
package:
  name: neuro_sensor

sources:
  - rtl/sensor_pkg.sv
  - rtl/wake_sequencer.sv
  - rtl/haar_dwt.sv
  - rtl/band_power.sv
  - rtl/peak_band_encoder.sv
  - rtl/manchester_tx.sv
  - rtl/neuro_sensor_top.sv
  - target: test
    files:
      - bench/sensor_props.sv
      - bench/tb_neuro_sensor.sv
